//--- logic/fir_pkg.sv
package fir_pkg;

   // ====================================================================
   // Widths and sizes
   // ====================================================================

   // Samples, coefficients, products and sums all share one width
   localparam int SAMPLE_WIDTH = 16;
   // Tree shape below is fixed to this many taps
   localparam int NUM_TAPS = 8;
   localparam int COEF_ADDR_WIDTH = 3;

   // Multiply-add pipeline depth, taps valid to y_out valid
   localparam int MAC_LATENCY = 5;
   // One extra cycle for the tap delay line
   localparam int FIR_LATENCY = MAC_LATENCY + 1;

   // ====================================================================
   // Types
   // ====================================================================

   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // Filter input word with its strobe
   typedef struct packed {
      logic    valid;
      sample_t data;
   } sample_in_t;

   // Coefficient write port
   typedef struct packed {
      logic                       we;
      logic [COEF_ADDR_WIDTH-1:0] addr;
      sample_t                    data;
   } coef_wr_t;

   // Delay line contents, index 0 is the newest sample
   typedef struct packed {
      logic                     valid;
      sample_t [NUM_TAPS-1:0]   taps;
   } tap_set_t;

   // Coefficient i weights tap i
   typedef sample_t [NUM_TAPS-1:0] coef_set_t;

   // Filter output word with its strobe
   typedef struct packed {
      logic    valid;
      sample_t data;
   } fir_out_t;

endpackage

//--- logic/tap_delay_line.sv
`timescale 1ns/1ns

module tap_delay_line (
   input  logic                clk,
   input  logic                rst,
   input  fir_pkg::sample_in_t sample_in,
   output fir_pkg::tap_set_t   taps
);

   // ====================================================================
   // Shift register
   // ====================================================================

   // Shifts only on an accepted sample and holds through gaps
   // The valid flag is registered beside the taps, one cycle wide
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         // Samples before reset count as zero
         taps.valid <= 1'b0;
         taps.taps  <= '0;
      end
      else begin
         taps.valid <= sample_in.valid;
         if (sample_in.valid) begin
            // Every tap moves one place older
            for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--) begin
               taps.taps[i] <= taps.taps[i-1];
            end
            // Newest sample enters at tap 0
            taps.taps[0] <= sample_in.data;
         end
      end
   end

   // ====================================================================
   // Assertions
   // ====================================================================

   // Taps hold during gaps, so the tap 0 seen one cycle back is
   // the value it had at the last shift
   // A fresh tap set must therefore carry that value in tap 1
   assert property (
      @(posedge clk) disable iff (rst)
      taps.valid |-> taps.taps[1] == $past(taps.taps[0])
   )
   else $error("tap_delay_line tap 1 is not the previous tap 0");

   // Sample data entering must be known when it is accepted
   assert property (
      @(posedge clk) disable iff (rst)
      sample_in.valid |-> !$isunknown(sample_in.data)
   )
   else $error("tap_delay_line accepted a sample with unknown bits");

endmodule

//--- logic/coef_bank.sv
`timescale 1ns/1ns

module coef_bank (
   input  logic               clk,
   input  logic               rst,
   input  fir_pkg::coef_wr_t  coef_wr,
   output fir_pkg::coef_set_t coefs
);

   // ====================================================================
   // Coefficient registers
   // ====================================================================

   fir_pkg::coef_set_t coefs_r;

   // Whole bank seen by the multiply-add stage
   assign coefs = coefs_r;

   // Addressed register loads on a write strobe
   // All others keep their value
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         coefs_r <= '0;
      end
      else if (coef_wr.we) begin
         coefs_r[coef_wr.addr] <= coef_wr.data;
      end
   end

   // ====================================================================
   // Assertions
   // ====================================================================

   // An unknown address could corrupt any register in the bank
   assert property (
      @(posedge clk) disable iff (rst)
      coef_wr.we |-> !$isunknown({coef_wr.addr, coef_wr.data})
   )
   else $error("coef_bank write with unknown address or data");

   // The write strobe itself must never be unknown out of reset
   assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown(coef_wr.we)
   )
   else $error("coef_bank write strobe unknown");

endmodule

//--- logic/mac_tree_pipeline.sv
`timescale 1ns/1ns

module mac_tree_pipeline (
   input  logic               clk,
   input  logic               rst,
   input  fir_pkg::tap_set_t  taps,
   input  fir_pkg::coef_set_t coefs,
   output fir_pkg::fir_out_t  y_out
);

   // Number of partial sums after each tree level
   localparam int L1_SUMS = fir_pkg::NUM_TAPS / 2;
   localparam int L2_SUMS = fir_pkg::NUM_TAPS / 4;

   // ====================================================================
   // Pipeline registers
   // ====================================================================

   // Stage 1, taps and coefficients captured together
   fir_pkg::sample_t [fir_pkg::NUM_TAPS-1:0] tap_r;
   fir_pkg::coef_set_t                       coef_r;
   // Stage 2, the eight products
   fir_pkg::sample_t [fir_pkg::NUM_TAPS-1:0] prod_r;
   // Stages 3 to 5, the adder tree levels
   fir_pkg::sample_t [L1_SUMS-1:0]           sum_l1_r;
   fir_pkg::sample_t [L2_SUMS-1:0]           sum_l2_r;
   fir_pkg::sample_t                         sum_l3_r;

   // Valid strobe travelling beside the data
   logic [fir_pkg::MAC_LATENCY-1:0] valid_r;

   // Warm-up counter for the latency checks
   logic [$clog2(fir_pkg::MAC_LATENCY+1)-1:0] warm_cnt;

   // ====================================================================
   // Datapath
   // ====================================================================

   // All arithmetic wraps at SAMPLE_WIDTH bits
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tap_r    <= '0;
         coef_r   <= '0;
         prod_r   <= '0;
         sum_l1_r <= '0;
         sum_l2_r <= '0;
         sum_l3_r <= '0;
      end
      else begin
         // Edge 1
         // coefficients are frozen here for this tap set
         tap_r  <= taps.taps;
         coef_r <= coefs;

         // Edge 2, tap i times coefficient i
         for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            prod_r[i] <= fir_pkg::sample_t'(tap_r[i] * coef_r[i]);
         end

         // Edge 3, pairs of products
         for (int i = 0; i < L1_SUMS; i++) begin
            sum_l1_r[i] <= fir_pkg::sample_t'(prod_r[2*i] + prod_r[2*i+1]);
         end

         // Edge 4, pairs of first-level sums
         for (int i = 0; i < L2_SUMS; i++) begin
            sum_l2_r[i] <= fir_pkg::sample_t'(sum_l1_r[2*i] + sum_l1_r[2*i+1]);
         end

         // Edge 5, final sum
         sum_l3_r <= fir_pkg::sample_t'(sum_l2_r[0] + sum_l2_r[1]);
      end
   end

   // ====================================================================
   // Valid delay chain
   // ====================================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end
      else begin
         // Stage 0 follows the tap set strobe
         valid_r[0] <= taps.valid;
         for (int i = 1; i < fir_pkg::MAC_LATENCY; i++) begin
            valid_r[i] <= valid_r[i-1];
         end
      end
   end

   // Output word and strobe leave together
   assign y_out.valid = valid_r[fir_pkg::MAC_LATENCY-1];
   assign y_out.data  = sum_l3_r;

   // ====================================================================
   // Assertions
   // ====================================================================

   // Counts edges since reset, saturating at the pipeline depth
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         warm_cnt <= '0;
      end
      else if (warm_cnt < fir_pkg::MAC_LATENCY) begin
         warm_cnt <= warm_cnt + 1'b1;
      end
   end

   // Nothing can come out before the pipe has filled once
   assert property (
      @(posedge clk) disable iff (rst)
      warm_cnt < fir_pkg::MAC_LATENCY |-> !y_out.valid
   )
   else $error("mac_tree_pipeline valid before pipeline filled");

   // Output strobe repeats the input strobe, gaps included
   assert property (
      @(posedge clk) disable iff (rst)
      warm_cnt == fir_pkg::MAC_LATENCY
         |-> y_out.valid == $past(taps.valid, fir_pkg::MAC_LATENCY)
   )
   else $error("mac_tree_pipeline valid latency mismatch");

endmodule

//--- logic/fir_filter_top.sv
`timescale 1ns/1ns

module fir_filter_top (
   input  logic                clk,
   input  logic                rst,
   input  fir_pkg::sample_in_t sample_in,
   input  fir_pkg::coef_wr_t   coef_wr,
   output fir_pkg::fir_out_t   y_out
);

   // ====================================================================
   // Internal connections
   // ====================================================================

   // Current tap set, one cycle behind sample_in
   fir_pkg::tap_set_t  taps;
   // Live coefficient bank
   fir_pkg::coef_set_t coefs;

   // ====================================================================
   // Instances
   // ====================================================================

   // Sample history
   tap_delay_line tap_delay_line_i (
      .clk       (clk),
      .rst       (rst),
      .sample_in (sample_in),
      .taps      (taps)
   );

   // Coefficient registers
   coef_bank coef_bank_i (
      .clk     (clk),
      .rst     (rst),
      .coef_wr (coef_wr),
      .coefs   (coefs)
   );

   // Multiply and reduce, total latency is one plus MAC_LATENCY
   mac_tree_pipeline mac_tree_pipeline_i (
      .clk   (clk),
      .rst   (rst),
      .taps  (taps),
      .coefs (coefs),
      .y_out (y_out)
   );

endmodule

//--- test/fir_checker.sv
`timescale 1ns/1ns

module fir_checker (
   input  logic                clk,
   input  logic                rst,
   input  fir_pkg::sample_in_t sample_in,
   input  fir_pkg::coef_wr_t   coef_wr,
   input  fir_pkg::fir_out_t   y_out,
   // Table value given beside its sample, valid only for table rows
   input  fir_pkg::fir_out_t   ref_out,
   output int                  pending,
   output int                  data_errs,
   output int                  timing_errs
);

   // ====================================================================
   // Reference model state
   // ====================================================================

   // Newest sample at index 0
   fir_pkg::sample_t  hist [fir_pkg::NUM_TAPS];
   fir_pkg::sample_t  coef_m [fir_pkg::NUM_TAPS];

   // Outputs still owed, oldest first
   int                due_q [$];
   fir_pkg::sample_t  exp_q [$];
   fir_pkg::fir_out_t ref_q [$];
   int                cycle;

   // Full sum of taps times weights, then wrapped to the sample width
   function automatic fir_pkg::sample_t model_output();
      int unsigned acc;
      acc = 0;
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
         acc += 32'(hist[i]) * 32'(coef_m[i]);
      end
      return fir_pkg::sample_t'(acc);
   endfunction

   // Output due this cycle must carry the strobe and the model value
   task automatic compare_output();
      if (due_q.size() > 0 && due_q[0] == cycle) begin
         if (!y_out.valid) begin
            $display("Output strobe missing at cycle %0d", cycle);
            timing_errs++;
         end
         else begin
            if (y_out.data !== exp_q[0]) begin
               $display("Error: y_out.data got 0x%h expected 0x%h at cycle %0d",
                        y_out.data, exp_q[0], cycle);
               data_errs++;
            end
            // Table value is checked on its own, independent of the model
            if (ref_q[0].valid && y_out.data !== ref_q[0].data) begin
               $display("Error: y_out.data got 0x%h table expected 0x%h at cycle %0d",
                        y_out.data, ref_q[0].data, cycle);
               data_errs++;
            end
         end
         void'(due_q.pop_front());
         void'(exp_q.pop_front());
         void'(ref_q.pop_front());
      end
      else if (y_out.valid) begin
         $display("Unexpected output strobe at cycle %0d with no sample due", cycle);
         timing_errs++;
      end
   endtask

   // ====================================================================
   // Per-edge tracking
   // ====================================================================

   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            hist[i]   = '0;
            coef_m[i] = '0;
         end
         due_q.delete();
         exp_q.delete();
         ref_q.delete();
         cycle       = 0;
         pending     = 0;
         data_errs   = 0;
         timing_errs = 0;
      end
      else begin
         cycle++;
         compare_output();
         // Weights seen by a sample are those in place after its edge
         if (coef_wr.we) begin
            coef_m[coef_wr.addr] = coef_wr.data;
         end
         if (sample_in.valid) begin
            for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--) begin
               hist[i] = hist[i-1];
            end
            hist[0] = sample_in.data;
            due_q.push_back(cycle + fir_pkg::FIR_LATENCY);
            exp_q.push_back(model_output());
            ref_q.push_back(ref_out);
         end
         pending = due_q.size();
      end
   end

endmodule

//--- test/fir_tb.sv
`timescale 1ns/1ns

module fir_tb;

   typedef enum logic [1:0] {ROW_IDLE, ROW_COEF, ROW_SAMPLE, ROW_DRAIN} row_kind_t;

   // One stimulus row, applied in one cycle
   typedef struct packed {
      row_kind_t                           kind;
      logic [fir_pkg::COEF_ADDR_WIDTH-1:0] addr;
      fir_pkg::sample_t                    value;
      logic                                has_exp;
      fir_pkg::sample_t                    exp_val;
   } row_t;

   logic                clk;
   logic                rst;
   fir_pkg::sample_in_t sample_in;
   fir_pkg::coef_wr_t   coef_wr;
   fir_pkg::fir_out_t   y_out;
   fir_pkg::fir_out_t   ref_out;
   int                  pending;
   int                  data_errs;
   int                  timing_errs;
   int                  timeouts;
   row_t                stim_q [$];
   logic [31:0]         rng;

   // ====================================================================
   // DUT and checker
   // ====================================================================

   fir_filter_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .sample_in (sample_in),
      .coef_wr   (coef_wr),
      .y_out     (y_out)
   );

   fir_checker check_i (
      .clk         (clk),
      .rst         (rst),
      .sample_in   (sample_in),
      .coef_wr     (coef_wr),
      .y_out       (y_out),
      .ref_out     (ref_out),
      .pending     (pending),
      .data_errs   (data_errs),
      .timing_errs (timing_errs)
   );

   // 4 ns period
   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   task automatic add_row(input row_kind_t kind,
                          input logic [fir_pkg::COEF_ADDR_WIDTH-1:0] addr,
                          input fir_pkg::sample_t value, input logic has_exp,
                          input fir_pkg::sample_t exp_val);
      row_t r;
      r.kind    = kind;
      r.addr    = addr;
      r.value   = value;
      r.has_exp = has_exp;
      r.exp_val = exp_val;
      stim_q.push_back(r);
   endtask

   task automatic idle_inputs();
      sample_in = '0;
      coef_wr   = '0;
      ref_out   = '0;
   endtask

   // Polls on falling edges until every owed output has come out
   task automatic wait_drain(input int limit);
      int waited;
      waited = 0;
      while (pending != 0 && waited < limit) begin
         @(negedge clk);
         waited++;
      end
      if (pending != 0) begin
         $display("Timeout: %0d outputs still owed after %0d cycles", pending, limit);
         timeouts++;
      end
   endtask

   task automatic apply_row(input row_t r);
      @(negedge clk);
      idle_inputs();
      case (r.kind)
         ROW_COEF: begin
            coef_wr.we   = 1'b1;
            coef_wr.addr = r.addr;
            coef_wr.data = r.value;
         end
         ROW_SAMPLE: begin
            sample_in.valid = 1'b1;
            sample_in.data  = r.value;
            ref_out.valid   = r.has_exp;
            ref_out.data    = r.exp_val;
         end
         ROW_DRAIN: wait_drain(32);
         default: ;
      endcase
   endtask

   // Random weights, then full-rate samples, then samples with gaps
   task automatic run_random(input int n_full, input int n_gapped);
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
         @(negedge clk);
         rng = xorshift32(rng);
         idle_inputs();
         coef_wr.we   = 1'b1;
         coef_wr.addr = i[2:0];
         coef_wr.data = rng[15:0];
      end
      for (int n = 0; n < n_full + n_gapped; n++) begin
         @(negedge clk);
         rng = xorshift32(rng);
         idle_inputs();
         // About one cycle in four is a gap once past the full-rate part
         sample_in.valid = (n < n_full) || (rng[19:18] != 2'b00);
         sample_in.data  = rng[15:0];
      end
      @(negedge clk);
      idle_inputs();
      wait_drain(64);
   endtask

   // ====================================================================
   // Stimulus
   // ====================================================================

   initial begin
      clk      = 1'b0;
      rst      = 1'b1;
      rng      = 32'd41;
      timeouts = 0;
      idle_inputs();

      // Quiet cycles, then weights 1 to 8
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
         add_row(ROW_COEF, i[2:0], 16'(i + 1), 1'b0, 16'd0);
      end
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      // Unit impulse reads the weights back in order
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
         add_row(ROW_SAMPLE, 3'd0, (i == 0) ? 16'd1 : 16'd0, 1'b1, 16'(i + 1));
      end
      add_row(ROW_DRAIN, 3'd0, 16'd0, 1'b0, 16'd0);
      // Only weight 2 changes, impulse repeated with gaps
      add_row(ROW_COEF, 3'd2, 16'h00f0, 1'b0, 16'd0);
      add_row(ROW_SAMPLE, 3'd0, 16'd1, 1'b1, 16'd1);
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'd2);
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'h00f0);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'd4);
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'd5);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'd6);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'd7);
      add_row(ROW_IDLE, 3'd0, 16'd0, 1'b0, 16'd0);
      add_row(ROW_SAMPLE, 3'd0, 16'd0, 1'b1, 16'd8);
      add_row(ROW_DRAIN, 3'd0, 16'd0, 1'b0, 16'd0);

      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int k = 0; k < stim_q.size(); k++) begin
         apply_row(stim_q[k]);
      end
      run_random(64, 160);

      $display("Check summary: %0d data errors, %0d timing errors, %0d timeouts",
               data_errs, timing_errs, timeouts);
      if (data_errs == 0 && timing_errs == 0 && timeouts == 0) begin
         $display("TEST PASSED");
      end
      else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- fir8.f
logic/fir_pkg.sv
logic/tap_delay_line.sv
logic/coef_bank.sv
logic/mac_tree_pipeline.sv
logic/fir_filter_top.sv
test/fir_checker.sv
test/fir_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= fir_tb
FILELIST   ?= fir8.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
